// File: logic/regFilePkg.sv
//**********************************************************
// Register file definitions for the ARM-style pipeline.
// Widths, register numbering and packed records shared by the
// register bank, the program counter and the IF/ID latch.
//**********************************************************
package regFilePkg;

  // data path and register width
  localparam int dataWidth = 32;

  // architectural registers including the pc
  localparam int regCount = 16;

  // enough bits to name every register
  localparam int addrWidth = 4;

  // r15 doubles as the program counter
  localparam int pcIndex = 15;

  // bytes between sequential instruction words
  localparam int pcStep = 4;

  // one register value
  typedef logic [dataWidth-1:0] word_t;

  // one register number
  typedef logic [addrWidth-1:0] regAddr_t;

  // write port request
  // en qualifies the whole record
  typedef struct packed {
    logic     en;
    regAddr_t addr;
    word_t    data;
  } regWrite_t;

  // instruction word split into named fields
  // fields overlap on purpose
  // the decode stage picks the ones its format needs
  typedef struct packed {
    // condition code, bits 31..28
    logic [3:0]  cond;
    // branch with link, bit 24
    logic        link;
    // S bit of data processing, bit 20
    logic        setFlags;
    // first operand register
    logic [3:0]  rn;
    // destination register
    logic [3:0]  rd;
    // second operand register
    logic [3:0]  rm;
    // shifter operand, low 12 bits
    logic [11:0] shifter;
    // branch offset, low 24 bits
    logic [23:0] offset;
  } instrFields_t;

endpackage

// File: logic/regBank.sv
//**********************************************************
// General register bank R0..R14 with one write port.
// Decodes the write address and serves three combinational
// read ports, with the pc supplied from outside for R15.
//**********************************************************
`timescale 1ns/10ps

module regBank
(
  input  logic                  clk,
  input  logic                  clr,
  // write request from writeback
  input  regFilePkg::regWrite_t wr,
  // read addresses, one per operand
  input  regFilePkg::regAddr_t  rdAddrA,
  input  regFilePkg::regAddr_t  rdAddrB,
  input  regFilePkg::regAddr_t  rdAddrC,
  // current program counter for reads of r15
  input  regFilePkg::word_t     pc,
  output regFilePkg::word_t     rdDataA,
  output regFilePkg::word_t     rdDataB,
  output regFilePkg::word_t     rdDataC,
  // write strobe for r15
  output logic                  pcWrite
);

  // one-hot write enables
  // one bit per architectural register
  logic [regFilePkg::regCount-1:0] wrSel;

  // all sixteen registers as seen by the read ports
  regFilePkg::word_t readView [regFilePkg::regCount];

  // write address decoder
  // nothing selected when the request is idle
  always_comb
  begin
    wrSel = '0;
    if (wr.en)
    begin
      wrSel[wr.addr] = 1'b1;
    end
  end

  // r15 lives in the pc unit
  // only its strobe leaves this block
  assign pcWrite = wrSel[regFilePkg::pcIndex];

  // general registers r0..r14
  for (genvar i = 0; i < regFilePkg::pcIndex; i++)
  begin : gGpr
    regFilePkg::word_t value;

    always_ff @(posedge clk or negedge clr)
    begin
      if (!clr)
      begin
        value <= '0;
      end
      else if (wrSel[i])
      begin
        value <= wr.data;
      end
    end

    // expose to the read muxes
    assign readView[i] = value;
  end

  // pc occupies the top slot
  assign readView[regFilePkg::pcIndex] = pc;

  // three independent read muxes
  // new data shows right after the write edge
  assign rdDataA = readView[rdAddrA];
  assign rdDataB = readView[rdAddrB];
  assign rdDataC = readView[rdAddrC];

endmodule

// File: logic/pcUnit.sv
//**********************************************************
// Program counter R15.
// Steps by one instruction per advance, an explicit write wins.
//**********************************************************
`timescale 1ns/10ps

module pcUnit
(
  input  logic              clk,
  input  logic              clr,
  // r15 strobe decoded in the register bank
  input  logic              pcWrite,
  // write port data, used only under pcWrite
  input  regFilePkg::word_t wrData,
  // fetch moves on to the next word
  input  logic              advance,
  output regFilePkg::word_t pc
);

  // value loaded at the next edge
  regFilePkg::word_t pcNext;

  // sequential address
  regFilePkg::word_t pcPlusStep;

  // increment by the instruction size
  assign pcPlusStep = pc + regFilePkg::word_t'(regFilePkg::pcStep);

  // next pc select
  // branch or explicit load first, then step, else hold
  always_comb
  begin
    if (pcWrite)
    begin
      pcNext = wrData;
    end
    else if (advance)
    begin
      pcNext = pcPlusStep;
    end
    else
    begin
      // fetch stalled
      pcNext = pc;
    end
  end

  // the pc register itself
  // starts fetching from address zero
  always_ff @(posedge clk or negedge clr)
  begin
    if (!clr)
    begin
      pc <= '0;
    end
    else
    begin
      pc <= pcNext;
    end
  end

endmodule

// File: logic/ifIdLatch.sv
//**********************************************************
// IF/ID pipeline latch.
// Captures the fetched word and its address under load and
// hands the decode stage the instruction as named fields.
//**********************************************************
`timescale 1ns/10ps

module ifIdLatch
(
  input  logic                     clk,
  input  logic                     clr,
  // capture enable, low stalls decode
  input  logic                     load,
  // word from instruction memory
  input  regFilePkg::word_t        instr,
  // address the word was fetched from
  input  regFilePkg::word_t        instrAddr,
  output regFilePkg::instrFields_t fields,
  output regFilePkg::word_t        decodedAddr
);

  // fields sliced ahead of the register
  regFilePkg::instrFields_t nextFields;

  // field extraction
  // pure wiring of bit ranges
  always_comb
  begin
    // condition code
    nextFields.cond     = instr[31:28];
    // L bit of branch
    nextFields.link     = instr[24];
    // S bit of data processing
    nextFields.setFlags = instr[20];
    // register numbers
    nextFields.rn       = instr[19:16];
    nextFields.rd       = instr[15:12];
    nextFields.rm       = instr[3:0];
    // shifter operand
    nextFields.shifter  = instr[11:0];
    // branch offset before sign extension
    nextFields.offset   = instr[23:0];
  end

  // latch register
  // holds both outputs while load is low
  always_ff @(posedge clk or negedge clr)
  begin
    if (!clr)
    begin
      fields      <= '0;
      decodedAddr <= '0;
    end
    else if (load)
    begin
      fields      <= nextFields;
      decodedAddr <= instrAddr;
    end
  end

endmodule

// File: logic/regFileCore.sv
//**********************************************************
// Register file core for the ARM-style pipeline.
// Joins the register bank, the program counter and the
// IF/ID latch into one block.
//**********************************************************
`timescale 1ns/10ps

module regFileCore
(
  input  logic                     clk,
  input  logic                     clr,
  // register write port
  input  regFilePkg::regWrite_t    wr,
  // operand reads
  input  regFilePkg::regAddr_t     rdAddrA,
  input  regFilePkg::regAddr_t     rdAddrB,
  input  regFilePkg::regAddr_t     rdAddrC,
  output regFilePkg::word_t        rdDataA,
  output regFilePkg::word_t        rdDataB,
  output regFilePkg::word_t        rdDataC,
  // program counter
  input  logic                     advance,
  output regFilePkg::word_t        pc,
  // IF/ID side
  input  logic                     instrLoad,
  input  regFilePkg::word_t        instr,
  input  regFilePkg::word_t        instrAddr,
  output regFilePkg::instrFields_t fields,
  output regFilePkg::word_t        decodedAddr
);

  // r15 write strobe from the bank decoder
  logic pcWrite;

  // r0..r14, write decode and read muxes
  // pc fed back in for reads of r15
  regBank u_regBank
  (
    .clk     (clk),
    .clr     (clr),
    .wr      (wr),
    .rdAddrA (rdAddrA),
    .rdAddrB (rdAddrB),
    .rdAddrC (rdAddrC),
    .pc      (pc),
    .rdDataA (rdDataA),
    .rdDataB (rdDataB),
    .rdDataC (rdDataC),
    .pcWrite (pcWrite)
  );

  // r15
  // same write data as the bank, its own strobe
  pcUnit u_pcUnit
  (
    .clk     (clk),
    .clr     (clr),
    .pcWrite (pcWrite),
    .wrData  (wr.data),
    .advance (advance),
    .pc      (pc)
  );

  // fetch to decode latch
  // independent of the register path
  ifIdLatch u_ifIdLatch
  (
    .clk         (clk),
    .clr         (clr),
    .load        (instrLoad),
    .instr       (instr),
    .instrAddr   (instrAddr),
    .fields      (fields),
    .decodedAddr (decodedAddr)
  );

endmodule

// File: testbench/regFileChecker.sv
//**********************************************************
// Checker for the register file core.
// Models registers, pc and IF/ID latch and compares each cycle.
//**********************************************************
`timescale 1ns/10ps

module regFileChecker
(
  input  logic                     clk,
  input  logic                     clr,
  input  regFilePkg::regWrite_t    wr,
  input  regFilePkg::regAddr_t     rdAddrA,
  input  regFilePkg::regAddr_t     rdAddrB,
  input  regFilePkg::regAddr_t     rdAddrC,
  input  regFilePkg::word_t        rdDataA,
  input  regFilePkg::word_t        rdDataB,
  input  regFilePkg::word_t        rdDataC,
  input  logic                     advance,
  input  regFilePkg::word_t        pc,
  input  logic                     instrLoad,
  input  regFilePkg::word_t        instr,
  input  regFilePkg::word_t        instrAddr,
  input  regFilePkg::instrFields_t fields,
  input  regFilePkg::word_t        decodedAddr,
  input  int                       testId,
  input  logic                     finished,
  output int                       errors,
  output int                       checks,
  output logic                     reported
);

  // register model
  // slot 15 stays unused since the pc has its own model
  regFilePkg::word_t        regModel [regFilePkg::regCount];
  regFilePkg::word_t        pcModel;
  regFilePkg::instrFields_t fieldsModel;
  regFilePkg::word_t        addrModel;

  int   errCount   = 0;
  int   checkCount = 0;
  int   lastTest   = 0;
  int   testErrors = 0;
  int   testChecks = 0;
  int   testsDone  = 0;
  logic doneFlag   = 1'b0;

  assign errors   = errCount;
  assign checks   = checkCount;
  assign reported = doneFlag;

  // ARM field positions from shifts and masks
  function automatic regFilePkg::instrFields_t sliceInstr(input regFilePkg::word_t w);
    regFilePkg::instrFields_t f;
    f.cond     = 4'((w >> 28) & 32'hf);
    f.link     = 1'((w >> 24) & 32'h1);
    f.setFlags = 1'((w >> 20) & 32'h1);
    f.rn       = 4'((w >> 16) & 32'hf);
    f.rd       = 4'((w >> 12) & 32'hf);
    f.rm       = 4'(w & 32'hf);
    f.shifter  = 12'(w & 32'hfff);
    f.offset   = 24'(w & 32'hffffff);
    return f;
  endfunction

  function automatic regFilePkg::word_t expectRead(input regFilePkg::regAddr_t a);
    return (a == regFilePkg::pcIndex) ? pcModel : regModel[a];
  endfunction

  function automatic string testName(input int id);
    case (id)
      1:       return "reset values";
      2:       return "general register writes";
      3:       return "pc stepping";
      4:       return "pc write override";
      5:       return "if/id latch";
      default: return "unknown";
    endcase
  endfunction

  task automatic checkValue(input string name, input logic [63:0] expected,
                            input logic [63:0] actual);
    checkCount++;
    testChecks++;
    if (actual !== expected)
    begin
      errCount++;
      testErrors++;
      $display("** Error at %0t: %s expected %h, got %h", $time, name, expected, actual);
    end
  endtask

  task automatic reportTest();
    testsDone++;
    $display("test %0d (%s): %0d checks, %0d errors, %s", lastTest, testName(lastTest),
             testChecks, testErrors, (testErrors == 0) ? "pass" : "fail");
  endtask

  // model update from the inputs sampled at the edge
  always @(posedge clk or negedge clr)
  begin
    if (!clr)
    begin
      foreach (regModel[i])
        regModel[i] = '0;
      pcModel     = '0;
      fieldsModel = '0;
      addrModel   = '0;
    end
    else
    begin
      // write to r15 wins over stepping
      if (wr.en && wr.addr == regFilePkg::pcIndex)
        pcModel = wr.data;
      else
      begin
        if (wr.en)
          regModel[wr.addr] = wr.data;
        if (advance)
          pcModel = pcModel + regFilePkg::pcStep;
      end
      if (instrLoad)
      begin
        fieldsModel = sliceInstr(instr);
        addrModel   = instrAddr;
      end
    end
  end

  // compare mid cycle once everything has settled
  // only out of reset
  always @(negedge clk)
  begin
    if (testId != lastTest)
    begin
      if (lastTest != 0)
        reportTest();
      lastTest   = testId;
      testErrors = 0;
      testChecks = 0;
    end
    if (finished)
    begin
      if (!doneFlag)
      begin
        reportTest();
        $display("summary: %0d tests, %0d checks, %0d errors", testsDone, checkCount, errCount);
        doneFlag = 1'b1;
      end
    end
    else if (clr)
    begin
      checkValue("rdDataA", expectRead(rdAddrA), rdDataA);
      checkValue("rdDataB", expectRead(rdAddrB), rdDataB);
      checkValue("rdDataC", expectRead(rdAddrC), rdDataC);
      checkValue("pc", pcModel, pc);
      checkValue("fields", fieldsModel, fields);
      checkValue("decodedAddr", addrModel, decodedAddr);
    end
  end

endmodule

// File: testbench/regFileTb.sv
//**********************************************************
// Testbench for the register file core.
// Table driven stimulus, comparisons live in regFileChecker.
//**********************************************************
`timescale 1ns/10ps

module regFileTb;

  // one row of the table is one clock cycle of stimulus
  typedef struct packed {
    logic [3:0]            test;
    // take write data and instr from the lfsr
    logic                  rnd;
    regFilePkg::regWrite_t wr;
    regFilePkg::regAddr_t  rdAddrA;
    regFilePkg::regAddr_t  rdAddrB;
    regFilePkg::regAddr_t  rdAddrC;
    logic                  advance;
    logic                  instrLoad;
    regFilePkg::word_t     instr;
    regFilePkg::word_t     instrAddr;
  } stimRow_t;

  localparam int clkPeriod    = 20;
  localparam int driveDelay   = 2;
  localparam int marginCycles = 10;

  logic                     clk;
  logic                     clr;
  regFilePkg::regWrite_t    wr;
  regFilePkg::regAddr_t     rdAddrA;
  regFilePkg::regAddr_t     rdAddrB;
  regFilePkg::regAddr_t     rdAddrC;
  regFilePkg::word_t        rdDataA;
  regFilePkg::word_t        rdDataB;
  regFilePkg::word_t        rdDataC;
  logic                     advance;
  regFilePkg::word_t        pc;
  logic                     instrLoad;
  regFilePkg::word_t        instr;
  regFilePkg::word_t        instrAddr;
  regFilePkg::instrFields_t fields;
  regFilePkg::word_t        decodedAddr;

  // checker side
  int   testId;
  logic finished;
  int   errors;
  int   checks;
  logic reported;

  logic        tableReady;
  stimRow_t    rows [$];
  logic [15:0] lfsrState;

  regFileCore i_dut (.*);

  regFileChecker i_chk (.*);

  always #(clkPeriod / 2) clk = ~clk;

  // fibonacci lfsr x^16+x^14+x^13+x^11+1
  // one step per bit taken
  function automatic regFilePkg::word_t randomWord();
    regFilePkg::word_t w;
    logic              fb;
    w = '0;
    for (int i = 0; i < regFilePkg::dataWidth; i++)
    begin
      fb        = lfsrState[15] ^ lfsrState[13] ^ lfsrState[12] ^ lfsrState[10];
      lfsrState = {lfsrState[14:0], fb};
      w         = {w[30:0], fb};
    end
    return w;
  endfunction

  task automatic addRow(input int test, input logic wrEn, input int wrAddr,
                        input logic [31:0] wrData, input int a, input int b, input int c,
                        input logic adv, input logic load, input logic [31:0] ins,
                        input logic [31:0] insAddr, input logic rnd);
    stimRow_t r;
    r.test      = test[3:0];
    r.rnd       = rnd;
    r.wr.en     = wrEn;
    r.wr.addr   = wrAddr[3:0];
    r.wr.data   = wrData;
    // address arithmetic wraps to four bits
    r.rdAddrA   = a[3:0];
    r.rdAddrB   = b[3:0];
    r.rdAddrC   = c[3:0];
    r.advance   = adv;
    r.instrLoad = load;
    r.instr     = ins;
    r.instrAddr = insAddr;
    rows.push_back(r);
  endtask

  task automatic buildTable();
    // reset values, every address over the three ports
    for (int i = 0; i < 6; i++)
      addRow(1, 0, 0, 0, 3 * i, 3 * i + 1, 3 * i + 2, 0, 0, 0, 0, 0);
    // write r0..r14, port B sees the previous write land
    for (int i = 0; i < regFilePkg::pcIndex; i++)
      addRow(2, 1, i, 0, i, i - 1, 15, 0, 0, 0, 0, 1);
    addRow(2, 0, 0, 0, 14, 3, 9, 0, 0, 0, 0, 0);
    addRow(2, 1, 5, 32'hdeadbeef, 5, 4, 6, 0, 0, 0, 0, 0);
    addRow(2, 0, 0, 0, 5, 4, 6, 0, 0, 0, 0, 0);
    addRow(2, 0, 0, 0, 12, 0, 7, 0, 0, 0, 0, 0);
    // pc stepping, then held
    for (int i = 0; i < 5; i++)
      addRow(3, 0, 0, 0, 15, 15, 1, 1, 0, 0, 0, 0);
    for (int i = 0; i < 2; i++)
      addRow(3, 0, 0, 0, 15, 2, 15, 0, 0, 0, 0, 0);
    // pc writes beat advance
    addRow(4, 1, 15, 32'h00008000, 15, 15, 15, 1, 0, 0, 0, 0);
    for (int i = 0; i < 3; i++)
      addRow(4, 0, 0, 0, 15, 15, 15, 1, 0, 0, 0, 0);
    addRow(4, 1, 15, 0, 15, 0, 15, 1, 0, 0, 0, 1);
    addRow(4, 0, 0, 0, 15, 15, 15, 1, 0, 0, 0, 0);
    addRow(4, 1, 15, 32'h00000100, 15, 15, 15, 0, 0, 0, 0, 0);
    addRow(4, 0, 0, 0, 15, 15, 15, 0, 0, 0, 0, 0);
    // if/id capture, stall with changing instr, fixed encodings
    for (int i = 0; i < 4; i++)
      addRow(5, 0, 0, 0, 0, 0, 0, 0, 1, 0, 32'h100 + 4 * i, 1);
    for (int i = 0; i < 3; i++)
      addRow(5, 0, 0, 0, 0, 0, 0, 0, 0, 0, 32'h200 + 4 * i, 1);
    addRow(5, 0, 0, 0, 0, 0, 0, 0, 1, 32'heb000010, 32'h300, 0);
    addRow(5, 0, 0, 0, 0, 0, 0, 0, 1, 32'he0912003, 32'h304, 0);
    addRow(5, 0, 0, 0, 0, 0, 0, 0, 0, 32'hffffffff, 32'h308, 0);
  endtask

  initial
  begin
    stimRow_t r;
    clk        = 1'b0;
    clr        = 1'b0;
    wr         = '0;
    rdAddrA    = '0;
    rdAddrB    = '0;
    rdAddrC    = '0;
    advance    = 1'b0;
    instrLoad  = 1'b0;
    instr      = '0;
    instrAddr  = '0;
    testId     = 1;
    finished   = 1'b0;
    tableReady = 1'b0;
    lfsrState  = 16'd39;
    buildTable();
    tableReady = 1'b1;
    repeat (2) @(posedge clk);
    #driveDelay;
    clr = 1'b1;
    foreach (rows[i])
    begin
      r = rows[i];
      if (r.rnd)
      begin
        r.wr.data = randomWord();
        r.instr   = randomWord();
      end
      @(posedge clk);
      #driveDelay;
      testId    = r.test;
      wr        = r.wr;
      rdAddrA   = r.rdAddrA;
      rdAddrB   = r.rdAddrB;
      rdAddrC   = r.rdAddrC;
      advance   = r.advance;
      instrLoad = r.instrLoad;
      instr     = r.instr;
      instrAddr = r.instrAddr;
    end
    // idle cycle so the last row's effects are compared too
    @(posedge clk);
    #driveDelay;
    wr.en     = 1'b0;
    advance   = 1'b0;
    instrLoad = 1'b0;
    @(posedge clk);
    #driveDelay;
    finished = 1'b1;
    wait (reported);
    if (errors == 0 && checks > 0)
    begin
      $display("TEST OK");
    end
    else
    begin
      if (checks == 0)
        $display("the checker made no comparisons");
      $display("TEST FAILED");
    end
    $finish;
  end

  // watchdog, sized from the table once it is built
  initial
  begin
    wait (tableReady);
    #((rows.size() + marginCycles) * clkPeriod);
    $display("watchdog expired at %0t, the stimulus never completed", $time);
    $display("TEST FAILED");
    $finish;
  end

endmodule

// File: sources.f
logic/regFilePkg.sv
logic/regBank.sv
logic/pcUnit.sv
logic/ifIdLatch.sv
logic/regFileCore.sv
testbench/regFileChecker.sv
testbench/regFileTb.sv

// File: Bender.yml
package:
  name: reg_file_core

sources:
  - logic/regFilePkg.sv
  - logic/regBank.sv
  - logic/pcUnit.sv
  - logic/ifIdLatch.sv
  - logic/regFileCore.sv
  - target: test
    files:
      - testbench/regFileChecker.sv
      - testbench/regFileTb.sv
